/* dcache_uncached.f */
+incdir+source
source/dcache_pkg.sv
source/mem_req_decode.sv
source/axi_lite_sequencer.sv
source/load_result_unit.sv
source/dcache_uncached.sv
bench/dcache_uncached_checker.sv
bench/dcache_uncached_tb.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = dcache_uncached_tb
FILELIST  = dcache_uncached.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -F -q 'All tests passed!'

clean:
	rm -rf obj_dir

/* bench/dcache_uncached_tb.sv */
// Data access unit testbench

`timescale 1ns/10ps

`include "dcache_uncached_config.svh"

module dcache_uncached_tb
    import dcache_pkg::*;
();

    localparam int TIMEOUT = 500;   // Cycles per wait

    typedef struct {
        string       name;
        mem_op_e     op;
        logic [63:0] addr;
        size_e       size;
        logic        uns;
        amo_fn_e     amo;
        logic [63:0] value;
        logic        exc;
        logic [63:0] exp_val;   // Response value, or cause when exc is set
    } test_t;

    test_t tests[$];
    int    seed = 81314;

    logic                  clk = 1'b0;
    logic                  rstn = 1'b0;
    logic                  req_valid = 1'b0;
    logic                  req_ready;
    logic [`DC_XLEN-1:0]   req_addr = '0;
    mem_op_e               req_op = MEM_LOAD;
    size_e                 req_size = SIZE_B;
    logic                  req_unsigned = 1'b0;
    amo_fn_e               req_amo = AMO_ADD;
    logic [`DC_XLEN-1:0]   req_value = '0;
    logic                  resp_valid;
    logic [`DC_XLEN-1:0]   resp_value;
    logic                  ex_valid;
    exc_cause_e            ex_cause;
    logic [`DC_XLEN-1:0]   ex_tval;
    logic                  ar_valid;
    logic                  ar_ready = 1'b0;
    logic [`DC_XLEN-1:0]   ar_addr;
    logic                  r_valid = 1'b0;
    logic                  r_ready;
    logic [`DC_XLEN-1:0]   r_data = '0;
    logic                  aw_valid;
    logic                  aw_ready = 1'b0;
    logic [`DC_XLEN-1:0]   aw_addr;
    logic                  w_valid;
    logic                  w_ready = 1'b0;
    logic [`DC_XLEN-1:0]   w_data;
    logic [`DC_STRB_W-1:0] w_strb;
    logic                  b_valid = 1'b0;
    logic                  b_ready;

    logic [63:0] mem [16];
    logic        aw_seen = 1'b0;
    logic        w_seen = 1'b0;

    dcache_uncached dut_i (.*);

    always #4 clk = ~clk;

    // Byte at memory address a after reset
    function automatic logic [7:0] pattern_byte(input int a);
        return 8'(a * 17);
    endfunction

    function automatic logic [63:0] expect_load(input int addr, input int s, input logic uns);
        logic [63:0] v;
        int          n;
        v = '0;
        n = 1 << s;
        for (int k = 0; k < n; k++) v[8*k +: 8] = pattern_byte(addr + k);
        if (!uns && v[8*n-1]) begin
            for (int k = 8 * n; k < 64; k++) v[k] = 1'b1;
        end
        return v;
    endfunction

    // AXI4-Lite memory with random readiness
    always @(posedge clk) begin
        if (!rstn) begin
            for (int w = 0; w < 16; w++) begin
                for (int b = 0; b < 8; b++) mem[w][8*b +: 8] <= pattern_byte(8 * w + b);
            end
            ar_ready <= 1'b0;
            aw_ready <= 1'b0;
            w_ready  <= 1'b0;
            r_valid  <= 1'b0;
            b_valid  <= 1'b0;
            aw_seen  <= 1'b0;
            w_seen   <= 1'b0;
        end else begin
            ar_ready <= ($random(seed) & 3) != 0;
            aw_ready <= ($random(seed) & 3) != 0;
            w_ready  <= ($random(seed) & 3) != 0;
            r_valid  <= ar_valid && ar_ready;
            if (ar_valid && ar_ready) r_data <= mem[ar_addr[6:3]];
            b_valid <= 1'b0;
            if (aw_valid && aw_ready) aw_seen <= 1'b1;
            if (w_valid && w_ready) w_seen <= 1'b1;
            if ((aw_seen || (aw_valid && aw_ready)) && (w_seen || (w_valid && w_ready))) begin
                for (int k = 0; k < 8; k++) begin
                    if (w_strb[k]) mem[aw_addr[6:3]][8*k +: 8] <= w_data[8*k +: 8];
                end
                b_valid <= 1'b1;   // Both channels done
                aw_seen <= 1'b0;
                w_seen  <= 1'b0;
            end
        end
    end

    task automatic add_test(input string name, input mem_op_e op, input logic [63:0] addr,
                            input size_e size, input logic uns, input amo_fn_e amo,
                            input logic [63:0] value, input logic exc, input logic [63:0] exp_val);
        test_t t;
        t = '{name, op, addr, size, uns, amo, value, exc, exp_val};
        tests.push_back(t);
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
            $display("Test failures found");
            $fatal(1, "Stopped at first mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out waiting for %s", what);
        $display("Test failures found");
        $fatal(1, "Wait limit exceeded");
    endtask

    task automatic run_test(input test_t t);
        int cnt;
        cnt = 0;
        @(negedge clk);
        while (!req_ready) begin
            cnt++;
            if (cnt > TIMEOUT) report_timeout("req_ready");
            @(negedge clk);
        end
        @(posedge clk);
        req_valid    <= 1'b1;
        req_addr     <= t.addr;
        req_op       <= t.op;
        req_size     <= t.size;
        req_unsigned <= t.uns;
        req_amo      <= t.amo;
        req_value    <= t.value;
        @(posedge clk);
        req_valid <= 1'b0;   // Accepted on this edge
        cnt = 0;
        @(negedge clk);
        while (!(resp_valid || ex_valid)) begin
            cnt++;
            if (cnt > TIMEOUT) report_timeout("resp_valid or ex_valid");
            @(negedge clk);
        end
        check_value({t.name, " ex_valid"}, {63'b0, t.exc}, {63'b0, ex_valid});
        // Response channels are always accepted
        check_value({t.name, " r_ready"}, 64'h1, {63'b0, r_ready});
        check_value({t.name, " b_ready"}, 64'h1, {63'b0, b_ready});
        if (t.exc) begin
            check_value({t.name, " cause"}, t.exp_val, {60'b0, ex_cause});
            check_value({t.name, " tval"}, t.addr, ex_tval);
        end else if (t.op != MEM_STORE) begin
            check_value(t.name, t.exp_val, resp_value);
        end
    endtask

    task automatic build_table();
        // Every size, offset and extension over words 0 to 2
        for (int s = 0; s < 4; s++) begin
            for (int a = 0; a < 24; a += 1 << s) begin
                for (int u = 0; u < 2; u++) begin
                    add_test($sformatf("ld_a%0d_s%0d_u%0d", a, s, u), MEM_LOAD, 64'(a),
                             size_e'(s[1:0]), u[0], AMO_ADD, 64'h0, 1'b0,
                             expect_load(a, s, u[0]));
                end
            end
        end
        add_test("st_half", MEM_STORE, 64'h1A, SIZE_H, 1'b0, AMO_ADD, 64'h1234, 1'b0, 64'h0);
        add_test("st_byte", MEM_STORE, 64'h1F, SIZE_B, 1'b0, AMO_ADD, 64'hAB, 1'b0, 64'h0);
        add_test("ld_merged", MEM_LOAD, 64'h18, SIZE_D, 1'b0, AMO_ADD, 64'h0, 1'b0,
                 64'hABFEEDDC1234A998);
        add_test("st_dword", MEM_STORE, 64'h20, SIZE_D, 1'b0, AMO_ADD, 64'h0123456789ABCDEF,
                 1'b0, 64'h0);
        add_test("st_word", MEM_STORE, 64'h24, SIZE_W, 1'b0, AMO_ADD, 64'hDEADBEEF, 1'b0, 64'h0);
        add_test("ld_dword", MEM_LOAD, 64'h20, SIZE_D, 1'b0, AMO_ADD, 64'h0, 1'b0,
                 64'hDEADBEEF89ABCDEF);
        add_test("ld_word_s", MEM_LOAD, 64'h24, SIZE_W, 1'b0, AMO_ADD, 64'h0, 1'b0,
                 64'hFFFFFFFFDEADBEEF);
        add_test("ld_half_u", MEM_LOAD, 64'h22, SIZE_H, 1'b1, AMO_ADD, 64'h0, 1'b0, 64'h89AB);
        // AMO chain on word 6 where each old value is the previous result
        add_test("amo_init", MEM_STORE, 64'h30, SIZE_D, 1'b0, AMO_ADD, 64'h10, 1'b0, 64'h0);
        add_test("amo_add", MEM_AMO, 64'h30, SIZE_D, 1'b0, AMO_ADD, 64'h5, 1'b0, 64'h10);
        add_test("amo_swap", MEM_AMO, 64'h30, SIZE_D, 1'b0, AMO_SWAP, 64'hFFFFFFFFFFFFFFF0,
                 1'b0, 64'h15);
        add_test("amo_min", MEM_AMO, 64'h30, SIZE_D, 1'b0, AMO_MIN, 64'h3, 1'b0,
                 64'hFFFFFFFFFFFFFFF0);
        add_test("amo_minu", MEM_AMO, 64'h30, SIZE_D, 1'b0, AMO_MINU, 64'h3, 1'b0,
                 64'hFFFFFFFFFFFFFFF0);
        add_test("amo_max", MEM_AMO, 64'h30, SIZE_D, 1'b0, AMO_MAX, 64'hFFFFFFFFFFFFFFFE,
                 1'b0, 64'h3);
        add_test("amo_maxu", MEM_AMO, 64'h30, SIZE_D, 1'b0, AMO_MAXU, 64'hFFFFFFFFFFFFFFFE,
                 1'b0, 64'h3);
        add_test("amo_xor", MEM_AMO, 64'h30, SIZE_D, 1'b0, AMO_XOR, 64'h0F, 1'b0,
                 64'hFFFFFFFFFFFFFFFE);
        add_test("amo_and", MEM_AMO, 64'h30, SIZE_D, 1'b0, AMO_AND, 64'hF3, 1'b0,
                 64'hFFFFFFFFFFFFFFF1);
        add_test("amo_or", MEM_AMO, 64'h30, SIZE_D, 1'b0, AMO_OR, 64'h100, 1'b0, 64'hF1);
        add_test("ld_amo", MEM_LOAD, 64'h30, SIZE_D, 1'b0, AMO_ADD, 64'h0, 1'b0, 64'h1F1);
        add_test("amo_add_w", MEM_AMO, 64'h3C, SIZE_W, 1'b0, AMO_ADD, 64'h4, 1'b0, 64'h2F1E0DFC);
        add_test("amo_minu_w", MEM_AMO, 64'h38, SIZE_W, 1'b0, AMO_MINU, 64'h7FFFFFFF, 1'b0,
                 64'hFFFFFFFFEBDAC9B8);
        add_test("ld_amo_w", MEM_LOAD, 64'h38, SIZE_D, 1'b0, AMO_ADD, 64'h0, 1'b0,
                 64'h2F1E0E007FFFFFFF);
        // Misaligned requests leave word 8 alone
        add_test("mis_ld", MEM_LOAD, 64'h41, SIZE_H, 1'b0, AMO_ADD, 64'h0, 1'b1, 64'd4);
        add_test("mis_st_w", MEM_STORE, 64'h42, SIZE_W, 1'b0, AMO_ADD, 64'hFFFFFFFF, 1'b1, 64'd6);
        add_test("mis_st_d", MEM_STORE, 64'h41, SIZE_D, 1'b0, AMO_ADD, 64'h0, 1'b1, 64'd6);
        add_test("mis_amo", MEM_AMO, 64'h44, SIZE_D, 1'b0, AMO_SWAP, 64'h0, 1'b1, 64'd6);
        add_test("ld_unchanged", MEM_LOAD, 64'h40, SIZE_D, 1'b0, AMO_ADD, 64'h0, 1'b0,
                 64'hB7A6958473625140);
    endtask

    initial begin
        build_table();
        repeat (3) @(posedge clk);
        rstn <= 1'b1;
        foreach (tests[i]) run_test(tests[i]);
        $display("All tests passed!");
        $finish;
    end

endmodule

/* bench/dcache_uncached_checker.sv */
// Bus handshake assertions

`timescale 1ns/10ps

`include "dcache_uncached_config.svh"

module dcache_uncached_checker (
    input logic                  clk,
    input logic                  rstn,
    input logic                  req_ready,
    input logic                  resp_valid,
    input logic                  ex_valid,
    input logic                  ar_valid,
    input logic                  ar_ready,
    input logic [`DC_XLEN-1:0]   ar_addr,
    input logic                  aw_valid,
    input logic                  aw_ready,
    input logic [`DC_XLEN-1:0]   aw_addr,
    input logic                  w_valid,
    input logic                  w_ready,
    input logic [`DC_XLEN-1:0]   w_data,
    input logic [`DC_STRB_W-1:0] w_strb
);

    ar_hold: assert property (@(posedge clk) disable iff (!rstn)
        ar_valid && !ar_ready |=> ar_valid && $stable(ar_addr))
        else $error("AR dropped or changed before ar_ready");

    aw_hold: assert property (@(posedge clk) disable iff (!rstn)
        aw_valid && !aw_ready |=> aw_valid && $stable(aw_addr))
        else $error("AW dropped or changed before aw_ready");

    w_hold: assert property (@(posedge clk) disable iff (!rstn)
        w_valid && !w_ready |=> w_valid && $stable(w_data) && $stable(w_strb))
        else $error("W dropped or changed before w_ready");

    // One response kind per request
    resp_ex_excl: assert property (@(posedge clk) disable iff (!rstn)
        !(resp_valid && ex_valid))
        else $error("resp_valid and ex_valid high together");

    busy_not_ready: assert property (@(posedge clk) disable iff (!rstn)
        (ar_valid || aw_valid || w_valid) |-> !req_ready)
        else $error("req_ready high during bus activity");

endmodule

bind dcache_uncached dcache_uncached_checker checker_i (
    .clk        (clk),
    .rstn       (rstn),
    .req_ready  (req_ready),
    .resp_valid (resp_valid),
    .ex_valid   (ex_valid),
    .ar_valid   (ar_valid),
    .ar_ready   (ar_ready),
    .ar_addr    (ar_addr),
    .aw_valid   (aw_valid),
    .aw_ready   (aw_ready),
    .aw_addr    (aw_addr),
    .w_valid    (w_valid),
    .w_ready    (w_ready),
    .w_data     (w_data),
    .w_strb     (w_strb)
);

/* source/dcache_uncached.sv */
// Uncached data access unit

`timescale 1ns/10ps

`include "dcache_uncached_config.svh"

module dcache_uncached
    import dcache_pkg::*;
(
    input  logic                  clk,
    input  logic                  rstn,
    // Core side
    input  logic                  req_valid,
    output logic                  req_ready,
    input  logic [`DC_XLEN-1:0]   req_addr,
    input  mem_op_e               req_op,
    input  size_e                 req_size,
    input  logic                  req_unsigned,
    input  amo_fn_e               req_amo,
    input  logic [`DC_XLEN-1:0]   req_value,
    output logic                  resp_valid,
    output logic [`DC_XLEN-1:0]   resp_value,
    output logic                  ex_valid,
    output exc_cause_e            ex_cause,
    output logic [`DC_XLEN-1:0]   ex_tval,
    // AXI4-Lite master
    output logic                  ar_valid,
    input  logic                  ar_ready,
    output logic [`DC_XLEN-1:0]   ar_addr,
    input  logic                  r_valid,
    output logic                  r_ready,
    input  logic [`DC_XLEN-1:0]   r_data,
    output logic                  aw_valid,
    input  logic                  aw_ready,
    output logic [`DC_XLEN-1:0]   aw_addr,
    output logic                  w_valid,
    input  logic                  w_ready,
    output logic [`DC_XLEN-1:0]   w_data,
    output logic [`DC_STRB_W-1:0] w_strb,
    input  logic                  b_valid,
    output logic                  b_ready
);

    logic                  misaligned;
    logic                  is_write;
    exc_cause_e            exc_cause;
    logic [`DC_STRB_W-1:0] strb;
    logic [`DC_XLEN-1:0]   wdata;
    logic [`DC_XLEN-1:0]   load_value;
    logic [`DC_XLEN-1:0]   amo_wdata;
    logic [`DC_OFF_W-1:0]  lat_off;
    size_e                 lat_size;
    logic                  lat_unsigned;
    amo_fn_e               lat_amo;
    logic [`DC_XLEN-1:0]   lat_operand;
    logic [`DC_XLEN-1:0]   rdata_q;

    mem_req_decode decode_i (
        .req_addr   (req_addr[`DC_OFF_W-1:0]),
        .req_size   (req_size),
        .req_op     (req_op),
        .req_value  (req_value),
        .misaligned (misaligned),
        .is_write   (is_write),
        .exc_cause  (exc_cause),
        .strb       (strb),
        .wdata      (wdata)
    );

    axi_lite_sequencer seq_i (
        .clk          (clk),
        .rstn         (rstn),
        .req_valid    (req_valid),
        .req_ready    (req_ready),
        .req_addr     (req_addr),
        .req_op       (req_op),
        .req_size     (req_size),
        .req_unsigned (req_unsigned),
        .req_amo      (req_amo),
        .req_value    (req_value),
        .misaligned   (misaligned),
        .is_write     (is_write),
        .exc_cause    (exc_cause),
        .strb         (strb),
        .wdata        (wdata),
        .load_value   (load_value),
        .amo_wdata    (amo_wdata),
        .lat_off      (lat_off),
        .lat_size     (lat_size),
        .lat_unsigned (lat_unsigned),
        .lat_amo      (lat_amo),
        .lat_operand  (lat_operand),
        .rdata_q      (rdata_q),
        .resp_valid   (resp_valid),
        .resp_value   (resp_value),
        .ex_valid     (ex_valid),
        .ex_cause     (ex_cause),
        .ex_tval      (ex_tval),
        .ar_valid     (ar_valid),
        .ar_ready     (ar_ready),
        .ar_addr      (ar_addr),
        .r_valid      (r_valid),
        .r_ready      (r_ready),
        .r_data       (r_data),
        .aw_valid     (aw_valid),
        .aw_ready     (aw_ready),
        .aw_addr      (aw_addr),
        .w_valid      (w_valid),
        .w_ready      (w_ready),
        .w_data       (w_data),
        .w_strb       (w_strb),
        .b_valid      (b_valid),
        .b_ready      (b_ready)
    );

    // Works on the latched request and the registered read beat
    load_result_unit result_i (
        .rdata       (rdata_q),
        .off         (lat_off),
        .size        (lat_size),
        .is_unsigned (lat_unsigned),
        .amo         (lat_amo),
        .operand     (lat_operand),
        .load_value  (load_value),
        .amo_wdata   (amo_wdata)
    );

endmodule

/* source/load_result_unit.sv */
// Load extraction and AMO ALU

`timescale 1ns/10ps

`include "dcache_uncached_config.svh"

module load_result_unit
    import dcache_pkg::*;
(
    input  logic [`DC_XLEN-1:0]  rdata,
    input  logic [`DC_OFF_W-1:0] off,
    input  size_e                size,
    input  logic                 is_unsigned,
    input  amo_fn_e              amo,
    input  logic [`DC_XLEN-1:0]  operand,
    output logic [`DC_XLEN-1:0]  load_value,
    output logic [`DC_XLEN-1:0]  amo_wdata
);

    // Widen the low bytes of a value to the full word
    function automatic logic [`DC_XLEN-1:0] extend(
        input logic [`DC_XLEN-1:0] value,
        input size_e               sz,
        input logic                zero_ext
    );
        logic fill;
        unique case (sz)
            SIZE_B: begin
                fill   = ~zero_ext & value[7];
                extend = {{(`DC_XLEN-8){fill}}, value[7:0]};
            end
            SIZE_H: begin
                fill   = ~zero_ext & value[15];
                extend = {{(`DC_XLEN-16){fill}}, value[15:0]};
            end
            SIZE_W: begin
                fill   = ~zero_ext & value[31];
                extend = {{(`DC_XLEN-32){fill}}, value[31:0]};
            end
            default: begin
                fill   = 1'b0;
                extend = value;
            end
        endcase
    endfunction

    logic [`DC_XLEN-1:0] lane_data;   // Addressed bytes moved to lane 0
    logic [`DC_XLEN-1:0] operand_ext;
    logic [`DC_XLEN-1:0] amo_result;
    logic                lt_signed;
    logic                lt_unsigned;

    assign lane_data   = rdata >> {off, 3'b000};
    assign load_value  = extend(lane_data, size, is_unsigned);
    assign operand_ext = extend(operand, size, 1'b0);

    // Word AMOs compare correctly on sign-extended operands
    assign lt_signed   = $signed(load_value) < $signed(operand_ext);
    assign lt_unsigned = load_value < operand_ext;

    always_comb begin
        unique case (amo)
            AMO_SWAP: amo_result = operand_ext;
            AMO_ADD:  amo_result = load_value + operand_ext;
            AMO_XOR:  amo_result = load_value ^ operand_ext;
            AMO_AND:  amo_result = load_value & operand_ext;
            AMO_OR:   amo_result = load_value | operand_ext;
            AMO_MIN:  amo_result = lt_signed ? load_value : operand_ext;
            AMO_MAX:  amo_result = lt_signed ? operand_ext : load_value;
            AMO_MINU: amo_result = lt_unsigned ? load_value : operand_ext;
            AMO_MAXU: amo_result = lt_unsigned ? operand_ext : load_value;
            default:  amo_result = load_value;   // Leave memory unchanged
        endcase
    end

    // Back into the byte lane of the request
    assign amo_wdata = amo_result << {off, 3'b000};

endmodule

/* source/axi_lite_sequencer.sv */
// AXI4-Lite access sequencer

`timescale 1ns/10ps

`include "dcache_uncached_config.svh"

module axi_lite_sequencer
    import dcache_pkg::*;
(
    input  logic                  clk,
    input  logic                  rstn,
    // Core request
    input  logic                  req_valid,
    output logic                  req_ready,
    input  logic [`DC_XLEN-1:0]   req_addr,
    input  mem_op_e               req_op,
    input  size_e                 req_size,
    input  logic                  req_unsigned,
    input  amo_fn_e               req_amo,
    input  logic [`DC_XLEN-1:0]   req_value,
    // Decode results
    input  logic                  misaligned,
    input  logic                  is_write,
    input  exc_cause_e            exc_cause,
    input  logic [`DC_STRB_W-1:0] strb,
    input  logic [`DC_XLEN-1:0]   wdata,
    // Result unit
    input  logic [`DC_XLEN-1:0]   load_value,
    input  logic [`DC_XLEN-1:0]   amo_wdata,
    output logic [`DC_OFF_W-1:0]  lat_off,
    output size_e                 lat_size,
    output logic                  lat_unsigned,
    output amo_fn_e               lat_amo,
    output logic [`DC_XLEN-1:0]   lat_operand,
    output logic [`DC_XLEN-1:0]   rdata_q,
    // Core response
    output logic                  resp_valid,
    output logic [`DC_XLEN-1:0]   resp_value,
    output logic                  ex_valid,
    output exc_cause_e            ex_cause,
    output logic [`DC_XLEN-1:0]   ex_tval,
    // AXI4-Lite master
    output logic                  ar_valid,
    input  logic                  ar_ready,
    output logic [`DC_XLEN-1:0]   ar_addr,
    input  logic                  r_valid,
    output logic                  r_ready,
    input  logic [`DC_XLEN-1:0]   r_data,
    output logic                  aw_valid,
    input  logic                  aw_ready,
    output logic [`DC_XLEN-1:0]   aw_addr,
    output logic                  w_valid,
    input  logic                  w_ready,
    output logic [`DC_XLEN-1:0]   w_data,
    output logic [`DC_STRB_W-1:0] w_strb,
    input  logic                  b_valid,
    output logic                  b_ready
);

    typedef enum logic [1:0] {
        IDLE,
        WAIT_R,    // Read address issued, waiting for R beat
        AMO,       // One cycle for the AMO ALU
        WAIT_W     // Write issued, waiting for B
    } state_e;

    state_e               state;
    logic [`DC_XLEN-1:0]  addr_q;
    mem_op_e              op_q;
    logic [`DC_XLEN-1:0]  amo_old_q;   // Old value returned by an AMO
    logic                 accept;

    assign req_ready = state == IDLE;
    assign accept    = req_valid && req_ready;

    assign ar_addr = addr_q;
    assign aw_addr = addr_q;
    assign lat_off = addr_q[`DC_OFF_W-1:0];
    assign r_ready = 1'b1;
    assign b_ready = 1'b1;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state      <= IDLE;
            ar_valid   <= 1'b0;
            aw_valid   <= 1'b0;
            w_valid    <= 1'b0;
            resp_valid <= 1'b0;
            ex_valid   <= 1'b0;
        end else begin
            resp_valid <= 1'b0;
            ex_valid   <= 1'b0;
            unique case (state)
                IDLE: begin
                    if (accept) begin
                        if (misaligned) begin
                            ex_valid <= 1'b1;    // No bus traffic
                        end else if (is_write) begin
                            aw_valid <= 1'b1;
                            w_valid  <= 1'b1;
                            state    <= WAIT_W;
                        end else begin
                            ar_valid <= 1'b1;
                            state    <= WAIT_R;
                        end
                    end
                end
                WAIT_R: begin
                    if (ar_ready) ar_valid <= 1'b0;
                    if (r_valid) begin
                        if (op_q == MEM_AMO) begin
                            state <= AMO;
                        end else begin
                            resp_valid <= 1'b1;
                            state      <= IDLE;
                        end
                    end
                end
                AMO: begin
                    aw_valid <= 1'b1;
                    w_valid  <= 1'b1;
                    state    <= WAIT_W;
                end
                WAIT_W: begin
                    if (aw_ready) aw_valid <= 1'b0;
                    if (w_ready) w_valid <= 1'b0;
                    if (b_valid) begin
                        resp_valid <= 1'b1;   // Error responses ignored
                        state      <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Request latches and bus payload
    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q       <= req_addr;
            op_q         <= req_op;
            lat_size     <= req_size;
            lat_unsigned <= req_unsigned;
            lat_amo      <= req_amo;
            lat_operand  <= req_value;
            w_strb       <= strb;
            w_data       <= wdata;
            ex_cause     <= exc_cause;
            ex_tval      <= req_addr;
        end
        if (state == WAIT_R && r_valid) rdata_q <= r_data;
        if (state == AMO) begin
            amo_old_q <= load_value;
            w_data    <= amo_wdata;
        end
    end

    always_comb begin
        case (op_q)
            MEM_LOAD: resp_value = load_value;
            MEM_AMO:  resp_value = amo_old_q;
            default:  resp_value = '0;   // Stores carry no value
        endcase
    end

endmodule

/* source/mem_req_decode.sv */
// Memory request decode

`timescale 1ns/10ps

`include "dcache_uncached_config.svh"

module mem_req_decode
    import dcache_pkg::*;
(
    input  logic [`DC_OFF_W-1:0]  req_addr,
    input  size_e                 req_size,
    input  mem_op_e               req_op,
    input  logic [`DC_XLEN-1:0]   req_value,
    output logic                  misaligned,
    output logic                  is_write,
    output exc_cause_e            exc_cause,
    output logic [`DC_STRB_W-1:0] strb,
    output logic [`DC_XLEN-1:0]   wdata
);

    logic                  aligned;
    logic [`DC_STRB_W-1:0] base_strb;   // Strobe for offset zero

    // Natural alignment of the low address bits
    always_comb begin
        unique case (req_size)
            SIZE_B: aligned = 1'b1;
            SIZE_H: aligned = req_addr[0] == 1'b0;
            SIZE_W: aligned = req_addr[1:0] == 2'b00;
            SIZE_D: aligned = req_addr == '0;
            default: aligned = 1'b0;
        endcase
    end

    assign misaligned = ~aligned;

    // AMOs read first, so only plain stores start on the write channels
    assign is_write = req_op == MEM_STORE;

    // AMO faults report as store faults
    assign exc_cause = (req_op == MEM_LOAD) ? EXC_LOAD_MISALIGN : EXC_STORE_MISALIGN;

    always_comb begin
        base_strb = '0;
        unique case (req_size)
            SIZE_B: base_strb[0]   = 1'b1;
            SIZE_H: base_strb[1:0] = '1;
            SIZE_W: base_strb[3:0] = '1;
            SIZE_D: base_strb      = '1;
            default: base_strb     = '0;
        endcase
    end

    // Move strobe and data into the addressed byte lanes
    assign strb  = base_strb << req_addr;
    assign wdata = req_value << {req_addr, 3'b000};

endmodule

/* source/dcache_pkg.sv */
// Data access unit types

package dcache_pkg;

    typedef enum logic [1:0] {
        MEM_LOAD  = 2'd0,
        MEM_STORE = 2'd1,
        MEM_AMO   = 2'd2
    } mem_op_e;

    typedef enum logic [1:0] {
        SIZE_B = 2'd0,  // 1 byte
        SIZE_H = 2'd1,
        SIZE_W = 2'd2,
        SIZE_D = 2'd3   // 8 bytes
    } size_e;

    // funct5 codes of the A extension
    typedef enum logic [4:0] {
        AMO_ADD  = 5'b00000,
        AMO_SWAP = 5'b00001,
        AMO_XOR  = 5'b00100,
        AMO_OR   = 5'b01000,
        AMO_AND  = 5'b01100,
        AMO_MIN  = 5'b10000,
        AMO_MAX  = 5'b10100,
        AMO_MINU = 5'b11000,
        AMO_MAXU = 5'b11100
    } amo_fn_e;

    // Standard mcause codes
    typedef enum logic [3:0] {
        EXC_LOAD_MISALIGN  = 4'd4,
        EXC_STORE_MISALIGN = 4'd6
    } exc_cause_e;

endpackage

/* source/dcache_uncached_config.svh */
// Uncached data access parameters

`ifndef DCACHE_UNCACHED_CONFIG_SVH
`define DCACHE_UNCACHED_CONFIG_SVH

// Data and address width of the core and of the bus
`define DC_XLEN 64

// One strobe per byte lane
`define DC_STRB_W 8

// Byte offset bits inside one bus word
`define DC_OFF_W 3

`endif
